/* dv/pic_vectors.txt */
# Columns: op, then hex arguments. W a0 data | R a0 expected | I ir_pattern
# A expected_vector | E expected_int_req | T test_name
# ICW1 edge mode with ICW4, ICW2 base A8, ICW4 8086 mode
W 0 11
W 1 A8
W 1 01
I 01
E 1
A A8
W 0 60
I 08
E 1
A AB
W 0 63
I 80
E 1
A AF
W 0 67
E 0
T nested
# All lines masked, then only level 2 opened
W 1 FF
I FF
E 0
W 1 FB
E 1
A AA
W 0 62
E 0
T mask
# Level mode flushes pending requests, then edge mode with AEOI
W 0 19
W 0 11
W 1 A8
W 1 03
I FF
A A8
A A9
A AA
A AB
A AC
A AD
A AE
A AF
W 0 0B
R 0 00
T aeoi
# Nested interrupts with non-specific EOI
W 0 11
W 1 A8
W 1 01
I 10
A AC
I 28
E 1
A AB
E 0
W 0 20
E 0
W 0 20
A AD
W 0 20
T nesting
# AEOI, then level 4 made lowest priority
W 0 11
W 1 A8
W 1 03
W 0 C4
I FF
A AD
A AE
A AF
A A8
A A9
A AA
A AB
A AC
T rotate
# IRR, ISR and IMR reads
W 0 11
W 1 A8
W 1 01
W 0 0A
I 24
R 0 24
W 0 0B
A AA
R 0 04
W 1 5A
R 1 5A
T status

/* list.f */
source/pic_pkg.sv
source/pic_bus_ctrl.sv
source/pic_request_reg.sv
source/pic_priority.sv
source/pic_in_service.sv
source/pic_control.sv
source/pic_top.sv
dv/pic_tb.sv

/* Makefile */
SIM = obj_dir/pic_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): list.f source/*.sv dv/pic_tb.sv
	verilator --binary --timing --assert --top-module pic_tb -f list.f -Mdir obj_dir -o pic_sim

run: $(SIM)
	$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Checks failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/pic_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pic_tb;

    logic           clk;
    logic           rst;
    logic           cs_n;
    logic           rd_n;
    logic           wr_n;
    logic           a0;
    pic_pkg::byte_t din;
    pic_pkg::byte_t ir;
    logic           inta_n;
    pic_pkg::byte_t dout;
    logic           int_req;

    int fd;
    int checks;
    int errors;
    int tests;
    int test_checks;
    int test_errors;

    pic_top u_pic_top (
        .clk     (clk),
        .rst     (rst),
        .cs_n    (cs_n),
        .rd_n    (rd_n),
        .wr_n    (wr_n),
        .a0      (a0),
        .din     (din),
        .ir      (ir),
        .inta_n  (inta_n),
        .dout    (dout),
        .int_req (int_req)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_byte(input pic_pkg::byte_t got, input pic_pkg::byte_t exp,
                              input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR t=%0d ns: %0s was %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR t=%0d ns: %0s was %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus and acknowledge drivers
    ////////////////////////////////////////////////////////////////////////////

    // Every driver starts and ends on a falling clock edge
    task automatic write_reg(input logic addr, input pic_pkg::byte_t data);
        @(negedge clk);
        cs_n = 1'b0;
        a0   = addr;
        din  = data;
        wr_n = 1'b0;
        repeat (2) @(negedge clk);
        wr_n = 1'b1;
        cs_n = 1'b1;
        din  = '0;
    endtask

    // Status appears two edges after rd_n falls
    task automatic read_check(input logic addr, input pic_pkg::byte_t exp);
        @(negedge clk);
        cs_n = 1'b0;
        a0   = addr;
        rd_n = 1'b0;
        repeat (3) @(negedge clk);
        check_byte(dout, exp, "status read");
        rd_n = 1'b1;
        cs_n = 1'b1;
    endtask

    task automatic request_pulse(input pic_pkg::byte_t pattern);
        @(negedge clk);
        ir = pattern;
        repeat (2) @(negedge clk);
        ir = '0;
    endtask

    task automatic wait_int(input logic level, output logic seen);
        int count;
        count = 0;
        checks++;
        while (int_req !== level && count < 20)
        begin
            @(negedge clk);
            count++;
        end
        seen = (int_req === level);
        if (!seen)
        begin
            errors++;
            $display("Timed out after 20 cycles waiting for int_req to become %0b", level);
        end
    endtask

    // A raised request must show up in time, a quiet one must stay low
    task automatic expect_int(input logic exp);
        logic seen;
        repeat (2) @(negedge clk);
        if (exp)
            wait_int(1'b1, seen);
        else
            check_int(int_req, exp, "int_req");
    endtask

    // CPU answers int_req with two INTA pulses and reads the vector on the second
    task automatic acknowledge(input pic_pkg::byte_t exp);
        logic seen;
        wait_int(1'b1, seen);
        if (seen)
        begin
            inta_n = 1'b0;
            @(negedge clk);
            inta_n = 1'b1;
            @(negedge clk);
            inta_n = 1'b0;
            repeat (2) @(negedge clk);
            check_byte(dout, exp, "INTA vector");
            inta_n = 1'b1;
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input logic [8*24-1:0] name);
        tests++;
        if (errors == test_errors)
            $display("Test %0s: %0d checks, ok", name, checks - test_checks);
        else
            $display("Test %0s: %0d checks, %0d errors, FAILED", name,
                     checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Vector replay
    ////////////////////////////////////////////////////////////////////////////

    task automatic replay_vectors();
        logic [7:0]       op;
        logic [7:0]       arg_a;
        logic [7:0]       arg_b;
        logic [8*24-1:0]  name;
        logic [8*128-1:0] rest;
        int               n;
        n = $fscanf(fd, "%s", op);
        while (n == 1)
        begin
            case (op)
                "#":
                    n = $fgets(rest, fd);
                "W":
                begin
                    n = $fscanf(fd, "%h %h", arg_a, arg_b);
                    if (n == 2)
                        write_reg(arg_a[0], arg_b);
                    else
                        n = 0;
                end
                "R":
                begin
                    n = $fscanf(fd, "%h %h", arg_a, arg_b);
                    if (n == 2)
                        read_check(arg_a[0], arg_b);
                    else
                        n = 0;
                end
                "I":
                begin
                    n = $fscanf(fd, "%h", arg_a);
                    if (n == 1)
                        request_pulse(arg_a);
                end
                "A":
                begin
                    n = $fscanf(fd, "%h", arg_a);
                    if (n == 1)
                        acknowledge(arg_a);
                end
                "E":
                begin
                    n = $fscanf(fd, "%h", arg_a);
                    if (n == 1)
                        expect_int(arg_a[0]);
                end
                "T":
                begin
                    n = $fscanf(fd, "%s", name);
                    if (n == 1)
                        finish_test(name);
                end
                default:
                    n = 0;
            endcase
            if (n > 0)
                n = $fscanf(fd, "%s", op);
            else
            begin
                errors++;
                $display("Vector line with op %c is unknown or incomplete, replay stopped", op);
            end
        end
    endtask

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        cs_n        = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        a0          = 1'b0;
        din         = '0;
        ir          = '0;
        inta_n      = 1'b1;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        test_checks = 0;
        test_errors = 0;
        fd = $fopen("dv/pic_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open dv/pic_vectors.txt for reading");
            $display("Checks failed");
            $finish;
        end
        else
        begin
            repeat (10) @(negedge clk);
            rst = 1'b0;
            replay_vectors();
            $fclose(fd);
            $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
            if (errors == 0)
                $display("All checks passed");
            else
                $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* source/pic_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pic_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           cs_n,
    input  logic           rd_n,
    input  logic           wr_n,
    input  logic           a0,
    input  pic_pkg::byte_t din,
    input  pic_pkg::byte_t ir,
    input  logic           inta_n,
    output pic_pkg::byte_t dout,
    output logic           int_req
);

    // CPU bus side
    logic            wr_stb;
    logic            wr_a0;
    logic            rd_active;
    logic            rd_a0;
    pic_pkg::byte_t  wr_data;
    pic_pkg::byte_t  status_byte;
    pic_pkg::byte_t  vector_byte;
    logic            vector_valid;

    // Core registers and priority
    pic_pkg::byte_t  irr;
    pic_pkg::byte_t  isr;
    pic_pkg::byte_t  imr;
    logic            req_valid;
    pic_pkg::level_t winner;
    logic            level_mode;
    logic            ack_latch;
    logic            eoi_nonspec;
    logic            eoi_spec;
    logic            aeoi_clear;
    pic_pkg::level_t ack_level;
    pic_pkg::level_t eoi_level;
    pic_pkg::level_t lowest_level;

    pic_bus_ctrl u_pic_bus_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cs_n         (cs_n),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .a0           (a0),
        .din          (din),
        .status_byte  (status_byte),
        .vector_valid (vector_valid),
        .vector_byte  (vector_byte),
        .wr_stb       (wr_stb),
        .wr_a0        (wr_a0),
        .rd_active    (rd_active),
        .rd_a0        (rd_a0),
        .wr_data      (wr_data),
        .dout         (dout)
    );

    pic_request_reg u_pic_request_reg (
        .clk        (clk),
        .rst        (rst),
        .ir         (ir),
        .level_mode (level_mode),
        .ack_latch  (ack_latch),
        .ack_level  (ack_level),
        .irr        (irr)
    );

    pic_priority u_pic_priority (
        .irr          (irr),
        .isr          (isr),
        .imr          (imr),
        .lowest_level (lowest_level),
        .req_valid    (req_valid),
        .winner       (winner)
    );

    pic_in_service u_pic_in_service (
        .clk          (clk),
        .rst          (rst),
        .ack_latch    (ack_latch),
        .eoi_nonspec  (eoi_nonspec),
        .eoi_spec     (eoi_spec),
        .aeoi_clear   (aeoi_clear),
        .ack_level    (ack_level),
        .eoi_level    (eoi_level),
        .lowest_level (lowest_level),
        .isr          (isr)
    );

    pic_control u_pic_control (
        .clk          (clk),
        .rst          (rst),
        .wr_stb       (wr_stb),
        .wr_a0        (wr_a0),
        .rd_a0        (rd_a0 & rd_active),
        .wr_data      (wr_data),
        .inta_n       (inta_n),
        .irr          (irr),
        .isr          (isr),
        .req_valid    (req_valid),
        .winner       (winner),
        .level_mode   (level_mode),
        .ack_latch    (ack_latch),
        .eoi_nonspec  (eoi_nonspec),
        .eoi_spec     (eoi_spec),
        .aeoi_clear   (aeoi_clear),
        .vector_valid (vector_valid),
        .int_req      (int_req),
        .ack_level    (ack_level),
        .eoi_level    (eoi_level),
        .lowest_level (lowest_level),
        .imr          (imr),
        .status_byte  (status_byte),
        .vector_byte  (vector_byte)
    );

endmodule

`default_nettype wire

/* source/pic_control.sv */
`timescale 1ns/100ps
`default_nettype none

module pic_control (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_stb,
    input  logic            wr_a0,
    input  logic            rd_a0,
    input  pic_pkg::byte_t  wr_data,
    input  logic            inta_n,
    input  pic_pkg::byte_t  irr,
    input  pic_pkg::byte_t  isr,
    input  logic            req_valid,
    input  pic_pkg::level_t winner,
    output logic            level_mode,
    output logic            ack_latch,
    output logic            eoi_nonspec,
    output logic            eoi_spec,
    output logic            aeoi_clear,
    output logic            vector_valid,
    output logic            int_req,
    output pic_pkg::level_t ack_level,
    output pic_pkg::level_t eoi_level,
    output pic_pkg::level_t lowest_level,
    output pic_pkg::byte_t  imr,
    output pic_pkg::byte_t  status_byte,
    output pic_pkg::byte_t  vector_byte
);

    pic_pkg::init_state_t init_state;
    pic_pkg::ack_state_t  ack_state;
    pic_pkg::ack_state_t  ack_next;
    pic_pkg::read_sel_t   read_sel;
    pic_pkg::ocw2_cmd_t   ocw2_cmd;
    pic_pkg::level_t      ack_level_q;
    logic [4:0]           vector_base;
    logic                 ic4;
    logic                 aeoi;
    logic                 inta_q;
    logic                 inta_fall;
    logic                 icw1_wr;
    logic                 ocw2_wr;

    ////////////////////////////////////////////////////////////////////////////
    // Command word decode
    ////////////////////////////////////////////////////////////////////////////

    assign icw1_wr  = wr_stb && !wr_a0 && wr_data[pic_pkg::ICW1_ID];
    assign ocw2_wr  = wr_stb && !wr_a0 && (init_state == pic_pkg::ready)
                      && !wr_data[pic_pkg::ICW1_ID] && !wr_data[pic_pkg::OCW3_ID];
    assign ocw2_cmd = pic_pkg::ocw2_cmd_t'(wr_data[7:5]);

    assign eoi_nonspec = ocw2_wr && (ocw2_cmd == pic_pkg::cmd_nonspec_eoi);
    assign eoi_spec    = ocw2_wr && (ocw2_cmd == pic_pkg::cmd_spec_eoi);
    assign eoi_level   = wr_data[2:0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            init_state   <= pic_pkg::wait_icw1;
            ic4          <= 1'b0;
            level_mode   <= 1'b0;
            aeoi         <= 1'b0;
            imr          <= '0;
            lowest_level <= 3'd7;
            read_sel     <= pic_pkg::sel_irr;
        end
        else if (icw1_wr)
        begin
            // SNGL is ignored and the device always runs single
            init_state   <= pic_pkg::wait_icw2;
            ic4          <= wr_data[pic_pkg::ICW1_IC4];
            level_mode   <= wr_data[pic_pkg::ICW1_LTIM];
            aeoi         <= 1'b0;
            imr          <= '0;
            lowest_level <= 3'd7;
            read_sel     <= pic_pkg::sel_irr;
        end
        else if (wr_stb)
        begin
            case (init_state)
                pic_pkg::wait_icw2:
                    if (wr_a0)
                        init_state <= ic4 ? pic_pkg::wait_icw4 : pic_pkg::ready;
                pic_pkg::wait_icw4:
                    if (wr_a0)
                    begin
                        aeoi       <= wr_data[pic_pkg::ICW4_AEOI];
                        init_state <= pic_pkg::ready;
                    end
                pic_pkg::ready:
                    if (wr_a0)
                        imr <= wr_data;
                    else if (wr_data[pic_pkg::OCW3_ID])
                    begin
                        // RIS in bit 0 only counts with RR set
                        if (wr_data[pic_pkg::OCW3_RR])
                            read_sel <= pic_pkg::read_sel_t'(wr_data[0]);
                    end
                    else if (ocw2_cmd == pic_pkg::cmd_set_priority)
                        lowest_level <= wr_data[2:0];
                default:
                    ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_stb && wr_a0 && (init_state == pic_pkg::wait_icw2))
            vector_base <= wr_data[7:3];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Acknowledge sequencer
    ////////////////////////////////////////////////////////////////////////////

    assign inta_fall = inta_q && !inta_n;

    always_comb
    begin
        ack_next = ack_state;
        case (ack_state)
            pic_pkg::ack_idle:   if (inta_fall) ack_next = pic_pkg::ack_first;
            pic_pkg::ack_first:  if (inta_fall) ack_next = pic_pkg::ack_second;
            pic_pkg::ack_second: if (inta_n) ack_next = pic_pkg::ack_idle;
            default:             ack_next = pic_pkg::ack_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ack_state <= pic_pkg::ack_idle;
            inta_q    <= 1'b1;
            int_req   <= 1'b0;
        end
        else
        begin
            ack_state <= ack_next;
            inta_q    <= inta_n;
            int_req   <= req_valid && (ack_next == pic_pkg::ack_idle)
                         && (init_state == pic_pkg::ready);
        end
    end

    always_ff @(posedge clk)
    begin
        if ((ack_state == pic_pkg::ack_idle) && inta_fall)
            ack_level_q <= winner;
    end

    // Live winner while idle and frozen once the first pulse is seen
    assign ack_level    = (ack_state == pic_pkg::ack_idle) ? winner : ack_level_q;
    assign ack_latch    = inta_fall && (ack_state == pic_pkg::ack_idle) && req_valid;
    assign vector_valid = (ack_state == pic_pkg::ack_second) && !inta_n;
    assign aeoi_clear   = aeoi && (ack_state == pic_pkg::ack_second) && inta_n;
    assign vector_byte  = {vector_base, ack_level};

    assign status_byte = rd_a0 ? imr : ((read_sel == pic_pkg::sel_isr) ? isr : irr);

    // Only a raised int_req is ever acknowledged
    ack_answers_int : assert property (@(posedge clk) disable iff (rst)
        ack_latch |-> int_req);

endmodule

`default_nettype wire

/* source/pic_in_service.sv */
`timescale 1ns/100ps
`default_nettype none

module pic_in_service (
    input  logic            clk,
    input  logic            rst,
    input  logic            ack_latch,
    input  logic            eoi_nonspec,
    input  logic            eoi_spec,
    input  logic            aeoi_clear,
    input  pic_pkg::level_t ack_level,
    input  pic_pkg::level_t eoi_level,
    input  pic_pkg::level_t lowest_level,
    output pic_pkg::byte_t  isr
);

    pic_pkg::byte_t  set_mask;
    pic_pkg::byte_t  clr_mask;
    pic_pkg::level_t top_level;
    pic_pkg::level_t scan_level;
    logic            top_found;

    // Highest-priority level currently in service
    always_comb
    begin
        top_found  = 1'b0;
        top_level  = '0;
        scan_level = '0;
        for (int k = 0; k < 8; k++)
        begin
            scan_level = lowest_level + pic_pkg::level_t'(k + 1);
            if (!top_found && isr[scan_level])
            begin
                top_found = 1'b1;
                top_level = scan_level;
            end
        end
    end

    assign set_mask = ack_latch ? (pic_pkg::byte_t'(1) << ack_level) : '0;

    always_comb
    begin
        clr_mask = '0;
        if (eoi_spec)
            clr_mask = clr_mask | (pic_pkg::byte_t'(1) << eoi_level);
        if (eoi_nonspec && top_found)
            clr_mask = clr_mask | (pic_pkg::byte_t'(1) << top_level);
        if (aeoi_clear)
            clr_mask = clr_mask | (pic_pkg::byte_t'(1) << ack_level);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            isr <= '0;
        else
            isr <= (isr | set_mask) & ~clr_mask;
    end

    // Priority logic must never pick a level that is already in service
    ack_not_in_service : assert property (@(posedge clk) disable iff (rst)
        ack_latch |-> !isr[ack_level]);

endmodule

`default_nettype wire

/* source/pic_priority.sv */
`timescale 1ns/100ps
`default_nettype none

module pic_priority (
    input  pic_pkg::byte_t  irr,
    input  pic_pkg::byte_t  isr,
    input  pic_pkg::byte_t  imr,
    input  pic_pkg::level_t lowest_level,
    output logic            req_valid,
    output pic_pkg::level_t winner
);

    pic_pkg::byte_t  req_rot;
    pic_pkg::byte_t  isr_rot;
    pic_pkg::level_t first_pos;
    logic            found;
    logic            blocked;

    // Index 0 is the level just after the lowest-priority one
    always_comb
    begin
        for (int j = 0; j < 8; j++)
        begin
            req_rot[j] = irr[lowest_level + pic_pkg::level_t'(j + 1)]
                         & ~imr[lowest_level + pic_pkg::level_t'(j + 1)];
            isr_rot[j] = isr[lowest_level + pic_pkg::level_t'(j + 1)];
        end
    end

    // Scan in priority order, stop at the first in-service or request bit
    always_comb
    begin
        found     = 1'b0;
        blocked   = 1'b0;
        first_pos = '0;
        for (int j = 0; j < 8; j++)
        begin
            if (!found && !blocked)
            begin
                if (isr_rot[j])
                    blocked = 1'b1;
                else if (req_rot[j])
                begin
                    found     = 1'b1;
                    first_pos = pic_pkg::level_t'(j);
                end
            end
        end
    end

    assign req_valid = found;
    assign winner    = lowest_level + first_pos + pic_pkg::level_t'(1);

endmodule

`default_nettype wire

/* source/pic_request_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pic_request_reg (
    input  logic            clk,
    input  logic            rst,
    input  pic_pkg::byte_t  ir,
    input  logic            level_mode,
    input  logic            ack_latch,
    input  pic_pkg::level_t ack_level,
    output pic_pkg::byte_t  irr
);

    pic_pkg::byte_t ir_q;
    pic_pkg::byte_t ir_rise;
    pic_pkg::byte_t ack_clr;

    assign ir_rise = ir & ~ir_q;
    assign ack_clr = ack_latch ? (pic_pkg::byte_t'(1) << ack_level) : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ir_q <= '0;
            irr  <= '0;
        end
        else
        begin
            ir_q <= ir;
            if (level_mode)
                irr <= ir;
            else
                // Edge request held until acknowledged, a fresh edge wins
                irr <= (irr & ~ack_clr) | ir_rise;
        end
    end

endmodule

`default_nettype wire

/* source/pic_bus_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module pic_bus_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           cs_n,
    input  logic           rd_n,
    input  logic           wr_n,
    input  logic           a0,
    input  pic_pkg::byte_t din,
    input  pic_pkg::byte_t status_byte,
    input  logic           vector_valid,
    input  pic_pkg::byte_t vector_byte,
    output logic           wr_stb,
    output logic           wr_a0,
    output logic           rd_active,
    output logic           rd_a0,
    output pic_pkg::byte_t wr_data,
    output pic_pkg::byte_t dout
);

    logic wr_n_q;
    logic rd_q;

    // One pulse per falling wr_n while selected
    assign wr_stb  = ~cs_n & ~wr_n & wr_n_q;
    assign wr_a0   = a0;
    assign wr_data = din;

    assign rd_active = ~cs_n & ~rd_n;
    assign rd_a0     = a0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_n_q <= 1'b1;
            rd_q   <= 1'b0;
        end
        else
        begin
            wr_n_q <= wr_n;
            rd_q   <= rd_active;
        end
    end

    // Vector wins over status and the bus idles at zero
    always_ff @(posedge clk)
    begin
        if (rst)
            dout <= '0;
        else if (vector_valid)
            dout <= vector_byte;
        else if (rd_active && rd_q)
            dout <= status_byte;
        else
            dout <= '0;
    end

    // The CPU never drives both strobes while selected
    rd_wr_exclusive : assert property (@(posedge clk) disable iff (rst)
        !(rd_active && !wr_n));

endmodule

`default_nettype wire

/* source/pic_pkg.sv */
`default_nettype none

package pic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] byte_t;
    typedef logic [2:0] level_t;

    ////////////////////////////////////////////////////////////////////////////
    // State and command encodings
    ////////////////////////////////////////////////////////////////////////////

    // Initialization word sequence
    typedef enum logic [1:0] {
        wait_icw1,
        wait_icw2,
        wait_icw4,
        ready
    } init_state_t;

    // Two-pulse INTA handshake
    typedef enum logic [1:0] {
        ack_idle,
        ack_first,
        ack_second
    } ack_state_t;

    // OCW2 bits 7..5, all other codes ignored
    typedef enum logic [2:0] {
        cmd_nonspec_eoi  = 3'b001,
        cmd_spec_eoi     = 3'b011,
        cmd_set_priority = 3'b110
    } ocw2_cmd_t;

    // Status register returned on an a0 = 0 read
    typedef enum logic {
        sel_irr,
        sel_isr
    } read_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bit positions in the command words
    ////////////////////////////////////////////////////////////////////////////

    localparam int ICW1_IC4  = 0;
    localparam int ICW1_LTIM = 3;
    localparam int ICW1_ID   = 4;

    localparam int ICW4_AEOI = 1;

    // OCW3 is told apart from OCW2 by bit 3
    localparam int OCW3_ID   = 3;
    localparam int OCW3_RR   = 1;

endpackage

`default_nettype wire
